/* logic/mem_pkg.sv */
package mem_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////

	// Byte address and data word
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// One enable per byte lane
	localparam int BE_W = DATA_W / 8;

	//////////////////////////////
	// Address map
	//////////////////////////////

	// 4 KiB of 32-bit words
	localparam int MEM_WORDS = 1024;
	localparam int IDX_W = 10;

	// Instruction region 0x000 - 0x3FF, data region up to 0xFFF
	localparam logic [ADDR_W-1:0] INSTR_END = 32'h0000_0400;
	localparam logic [ADDR_W-1:0] MEM_END = 32'h0000_1000;

	// AXI4-Lite response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// Owner and direction of port B in a cycle
	typedef enum logic [2:0] {
		OP_NONE,
		OP_CORE_RD,
		OP_CORE_WR,
		OP_HOST_RD,
		OP_HOST_WR
	} portb_op_e;

	// Host side of the port B arbiter
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HOST_PEND,
		ST_HOST_RESP
	} ctrl_state_e;

endpackage

/* logic/addr_decode.sv */
`timescale 1ns/10ps

module addr_decode import mem_pkg::*; (
	// Byte addresses from the three clients
	input  logic [ADDR_W-1:0] instr_addr,
	input  logic [ADDR_W-1:0] data_addr,
	input  logic [ADDR_W-1:0] host_addr,

	// Word indices into the shared array
	output logic [IDX_W-1:0]  instr_idx,
	output logic [IDX_W-1:0]  data_idx,
	output logic [IDX_W-1:0]  host_idx,

	// Region violations
	output logic              instr_bad,
	output logic              data_bad,
	output logic              host_bad
);

	//////////////////////////////
	// Word index
	//////////////////////////////

	// Drop byte offset, keep enough bits for 1024 words
	assign instr_idx = instr_addr[IDX_W+1:2];
	assign data_idx = data_addr[IDX_W+1:2];
	assign host_idx = host_addr[IDX_W+1:2];

	//////////////////////////////
	// Region checks
	//////////////////////////////

	// Fetch only from 0x000 - 0x3FF
	assign instr_bad = (instr_addr >= INSTR_END);

	// Core data only in 0x400 - 0xFFF
	always_comb begin
		data_bad = 1'b0;
		if (data_addr < INSTR_END) begin
			data_bad = 1'b1;
		end
		if (data_addr >= MEM_END) begin
			data_bad = 1'b1;
		end
	end

	// Host sees the full map; anything past it errors
	assign host_bad = (host_addr >= MEM_END);

endmodule

/* logic/dual_port_ram.sv */
`timescale 1ns/10ps

module dual_port_ram import mem_pkg::*; (
	input  logic              clk,

	// Port A, instruction reads only
	input  logic              a_en,
	input  logic [IDX_W-1:0]  a_idx,
	output logic [DATA_W-1:0] a_rdata,

	// Port B, shared by core data and host
	input  logic              b_en,
	input  logic              b_we,
	input  logic [BE_W-1:0]   b_be,
	input  logic [IDX_W-1:0]  b_idx,
	input  logic [DATA_W-1:0] b_wdata,
	output logic [DATA_W-1:0] b_rdata
);

	// Word storage, no init
	logic [DATA_W-1:0] mem [MEM_WORDS];

	//////////////////////////////
	// Port A
	//////////////////////////////

	// Registered read, data valid the cycle after a_en
	always_ff @(posedge clk) begin
		if (a_en) begin
			a_rdata <= mem[a_idx];
		end
	end

	//////////////////////////////
	// Port B
	//////////////////////////////

	// Read-first; old word lands on b_rdata during a write
	always_ff @(posedge clk) begin
		if (b_en) begin
			if (b_we) begin
				// Only lanes with enable set
				for (int i = 0; i < BE_W; i++) begin
					if (b_be[i]) begin
						mem[b_idx][8*i +: 8] <= b_wdata[8*i +: 8];
					end
				end
			end
			b_rdata <= mem[b_idx];
		end
	end

endmodule

/* logic/axil_slave.sv */
`timescale 1ns/10ps

module axil_slave import mem_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,

	// Write address and data
	input  logic [ADDR_W-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  logic [DATA_W-1:0] wdata,
	input  logic [BE_W-1:0]   wstrb,
	input  logic              wvalid,
	output logic              wready,

	// Write response
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,

	// Read address and data
	input  logic [ADDR_W-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	output logic [DATA_W-1:0] rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready,

	// Captured request toward mem_ctrl
	output logic              host_req,
	output logic              host_we,
	output logic [ADDR_W-1:0] host_addr,
	output logic [DATA_W-1:0] host_wdata,
	output logic [BE_W-1:0]   host_wstrb,

	// Completion from mem_ctrl
	input  logic              host_done,
	input  logic [DATA_W-1:0] host_rdata,
	input  logic              host_err
);

	// Busy from acceptance until response taken
	logic pend;
	logic aw_fire;
	logic ar_fire;

	//////////////////////////////
	// Acceptance
	//////////////////////////////

	// AW and W go together, only when idle
	assign awready = !pend && awvalid && wvalid;
	assign wready = awready;

	// Reads wait while any write channel is active
	assign arready = !pend && arvalid && !awvalid && !wvalid;

	assign aw_fire = awvalid && awready;
	assign ar_fire = arvalid && arready;

	//////////////////////////////
	// Control state
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend <= 1'b0;
			host_req <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			// New transaction, request goes out next cycle
			if (aw_fire || ar_fire) begin
				pend <= 1'b1;
				host_req <= 1'b1;
			end
			// Memory side finished, raise the matching response
			if (host_done) begin
				host_req <= 1'b0;
				bvalid <= host_we;
				rvalid <= !host_we;
			end
			// Free once the host takes the response
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				pend <= 1'b0;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				pend <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Transaction register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			host_we <= 1'b1;
			host_addr <= awaddr;
			host_wdata <= wdata;
			host_wstrb <= wstrb;
		end else if (ar_fire) begin
			host_we <= 1'b0;
			host_addr <= araddr;
		end
		// Response payload, error reads return zero
		if (host_done) begin
			bresp <= host_err ? RESP_SLVERR : RESP_OKAY;
			rresp <= host_err ? RESP_SLVERR : RESP_OKAY;
			rdata <= host_err ? '0 : host_rdata;
		end
	end

endmodule

/* logic/mem_ctrl.sv */
`timescale 1ns/10ps

module mem_ctrl import mem_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,

	// Requests and decode results
	input  logic              instr_rd,
	input  logic              instr_bad,
	input  logic              data_req,
	input  logic              data_we,
	input  logic              data_bad,
	input  logic              host_req,
	input  logic              host_we,
	input  logic              host_bad,

	// RAM side
	input  logic [DATA_W-1:0] a_rdata,
	input  logic [DATA_W-1:0] b_rdata,
	output logic              a_en,
	output logic              b_en,
	output logic              b_we,
	output portb_op_e         portb_op,

	// Core side
	output logic              data_gnt,
	output logic              instr_valid,
	output logic [DATA_W-1:0] instr_rdata,
	output logic              instr_fault,
	output logic              data_rvalid,
	output logic [DATA_W-1:0] data_rdata,
	output logic              data_fault,

	// Host side
	output logic              host_done,
	output logic [DATA_W-1:0] host_rdata,
	output logic              host_err
);

	ctrl_state_e state, state_d;
	logic        host_gnt;
	logic        issue_bad;

	// Last cycle's issue record
	logic        instr_rd_q;
	logic        instr_bad_q;
	portb_op_e   op_q;
	logic        fault_q;

	//////////////////////////////
	// Port B arbitration
	//////////////////////////////

	// Core never waits
	assign data_gnt = data_req;

	// Host goes only in a cycle free of core traffic
	assign host_gnt = host_req && !data_req &&
		(state == ST_IDLE || state == ST_HOST_PEND);

	always_comb begin
		state_d = state;
		case (state)
			ST_IDLE: if (host_req) state_d = data_req ? ST_HOST_PEND : ST_HOST_RESP;
			ST_HOST_PEND: if (!data_req) state_d = ST_HOST_RESP;
			// host_done cycle, host_req still high here
			default: state_d = ST_IDLE;
		endcase
	end

	always_comb begin
		portb_op = OP_NONE;
		if (data_req) begin
			portb_op = data_we ? OP_CORE_WR : OP_CORE_RD;
		end else if (host_gnt) begin
			portb_op = host_we ? OP_HOST_WR : OP_HOST_RD;
		end
	end

	// Fault of whoever owns port B this cycle
	assign issue_bad = data_req ? data_bad : host_bad;

	// Faulting accesses never reach the array
	assign a_en = instr_rd && !instr_bad;
	assign b_en = (portb_op != OP_NONE) && !issue_bad;
	assign b_we = b_en && (portb_op == OP_CORE_WR || portb_op == OP_HOST_WR);

	//////////////////////////////
	// State and issue record
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			instr_rd_q <= 1'b0;
			instr_bad_q <= 1'b0;
			op_q <= OP_NONE;
			fault_q <= 1'b0;
		end else begin
			state <= state_d;
			instr_rd_q <= instr_rd;
			instr_bad_q <= instr_bad;
			op_q <= portb_op;
			fault_q <= issue_bad;
		end
	end

	//////////////////////////////
	// Return paths
	//////////////////////////////

	// Instruction port, zero unless a good fetch
	assign instr_valid = instr_rd_q;
	assign instr_fault = instr_rd_q && instr_bad_q;
	assign instr_rdata = (instr_rd_q && !instr_bad_q) ? a_rdata : '0;

	// Core data, writes return zero
	assign data_rvalid = (op_q == OP_CORE_RD) || (op_q == OP_CORE_WR);
	assign data_fault = data_rvalid && fault_q;
	assign data_rdata = (op_q == OP_CORE_RD && !fault_q) ? b_rdata : '0;

	// Host completion
	assign host_done = (op_q == OP_HOST_RD) || (op_q == OP_HOST_WR);
	assign host_err = host_done && fault_q;
	assign host_rdata = (op_q == OP_HOST_RD && !fault_q) ? b_rdata : '0;

endmodule

/* logic/mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top import mem_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,

	// Instruction port
	input  logic              instr_rd,
	input  logic [ADDR_W-1:0] instr_addr,
	output logic              instr_valid,
	output logic [DATA_W-1:0] instr_rdata,
	output logic              instr_fault,

	// Core data port
	input  logic              data_req,
	input  logic              data_we,
	input  logic [ADDR_W-1:0] data_addr,
	input  logic [DATA_W-1:0] data_wdata,
	input  logic [BE_W-1:0]   data_be,
	output logic              data_gnt,
	output logic              data_rvalid,
	output logic [DATA_W-1:0] data_rdata,
	output logic              data_fault,

	// Host AXI4-Lite
	input  logic [ADDR_W-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  logic [DATA_W-1:0] wdata,
	input  logic [BE_W-1:0]   wstrb,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	input  logic [ADDR_W-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	output logic [DATA_W-1:0] rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready
);

	// Decoder outputs
	logic [IDX_W-1:0]  instr_idx;
	logic [IDX_W-1:0]  data_idx;
	logic [IDX_W-1:0]  host_idx;
	logic              instr_bad;
	logic              data_bad;
	logic              host_bad;

	// Host request
	logic              host_req;
	logic              host_we;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic [BE_W-1:0]   host_wstrb;
	logic              host_done;
	logic [DATA_W-1:0] host_rdata;
	logic              host_err;

	// RAM ports
	logic              a_en;
	logic [DATA_W-1:0] a_rdata;
	logic              b_en;
	logic              b_we;
	logic [BE_W-1:0]   b_be;
	logic [IDX_W-1:0]  b_idx;
	logic [DATA_W-1:0] b_wdata;
	logic [DATA_W-1:0] b_rdata;
	portb_op_e         portb_op;
	logic              host_sel;

	//////////////////////////////
	// Port B steering
	//////////////////////////////

	// Host fields only in a host grant cycle
	assign host_sel = (portb_op == OP_HOST_RD) || (portb_op == OP_HOST_WR);
	assign b_idx = host_sel ? host_idx : data_idx;
	assign b_wdata = host_sel ? host_wdata : data_wdata;
	assign b_be = host_sel ? host_wstrb : data_be;

	//////////////////////////////
	// Blocks
	//////////////////////////////

	addr_decode addr_decode_inst (
		.instr_addr (instr_addr),
		.data_addr  (data_addr),
		.host_addr  (host_addr),
		.instr_idx  (instr_idx),
		.data_idx   (data_idx),
		.host_idx   (host_idx),
		.instr_bad  (instr_bad),
		.data_bad   (data_bad),
		.host_bad   (host_bad)
	);

	// Port A is read-only; instructions come in through the host
	dual_port_ram dual_port_ram_inst (
		.clk     (clk),
		.a_en    (a_en),
		.a_idx   (instr_idx),
		.a_rdata (a_rdata),
		.b_en    (b_en),
		.b_we    (b_we),
		.b_be    (b_be),
		.b_idx   (b_idx),
		.b_wdata (b_wdata),
		.b_rdata (b_rdata)
	);

	axil_slave axil_slave_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_wstrb (host_wstrb),
		.host_done  (host_done),
		.host_rdata (host_rdata),
		.host_err   (host_err)
	);

	mem_ctrl mem_ctrl_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_rd    (instr_rd),
		.instr_bad   (instr_bad),
		.data_req    (data_req),
		.data_we     (data_we),
		.data_bad    (data_bad),
		.host_req    (host_req),
		.host_we     (host_we),
		.host_bad    (host_bad),
		.a_rdata     (a_rdata),
		.b_rdata     (b_rdata),
		.a_en        (a_en),
		.b_en        (b_en),
		.b_we        (b_we),
		.portb_op    (portb_op),
		.data_gnt    (data_gnt),
		.instr_valid (instr_valid),
		.instr_rdata (instr_rdata),
		.instr_fault (instr_fault),
		.data_rvalid (data_rvalid),
		.data_rdata  (data_rdata),
		.data_fault  (data_fault),
		.host_done   (host_done),
		.host_rdata  (host_rdata),
		.host_err    (host_err)
	);

endmodule

/* bench/tb_mem_subsys.sv */
`timescale 1ns/10ps

module tb_mem_subsys import mem_pkg::*; ();

	logic              clk = 1'b0;
	logic              arst_n;
	logic              instr_rd, data_req, data_we;
	logic [ADDR_W-1:0] instr_addr, data_addr, awaddr, araddr;
	logic [DATA_W-1:0] data_wdata, wdata;
	logic [BE_W-1:0]   data_be, wstrb;
	logic              awvalid, wvalid, bready, arvalid, rready;
	logic              instr_valid, instr_fault, data_gnt, data_rvalid, data_fault;
	logic [DATA_W-1:0] instr_rdata, data_rdata, rdata;
	logic              awready, wready, bvalid, arready, rvalid;
	logic [1:0]        bresp, rresp;

	// Step table from the data file
	logic [15:0]       step_op [64];
	logic [31:0]       step_addr [64];
	logic [31:0]       step_wdata [64];
	logic [3:0]        step_strb [64];
	logic [31:0]       step_exp [64];
	int                step_flt [64];
	int                step_noise [64];
	int                n_steps = 0;

	// Reference memory with a known flag per word
	logic [31:0]       model [MEM_WORDS];
	bit                known [MEM_WORDS];
	int                errors = 0;
	int                cycles = 0;
	int                limit = 100000;
	bit                noise_on = 1'b0;

	mem_subsys_top mem_subsys_top_inst (.*);

	always #5 clk = ~clk;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// Byte lanes with strobe set take the new value
	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
		input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) res[8*i +: 8] = nw[8*i +: 8];
		end
		return res;
	endfunction

	task automatic update_model(input logic [31:0] addr, input logic [31:0] wd,
		input logic [3:0] be);
		int idx;
		idx = addr[11:2];
		if (known[idx] || be == 4'hf) begin
			model[idx] = merge(model[idx], wd, be);
			known[idx] = 1'b1;
		end
	endtask

	//////////////////////////////
	// Host side
	//////////////////////////////

	// New request offered while a response is held, AW/W and AR in turn
	task automatic offer_blocked(input int k);
		@(posedge clk);
		#1;
		awvalid = !k[0];
		wvalid = !k[0];
		arvalid = k[0];
		@(negedge clk);
		if (k[0]) begin
			check_val("arready", 0, arready);
		end else begin
			check_val("awready", 0, awready);
			check_val("wready", 0, wready);
		end
	endtask

	task automatic host_write(input logic [31:0] addr, input logic [31:0] wd,
		input logic [3:0] st, input int flt);
		int stall;
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = wd;
		wstrb = st;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do @(negedge clk); while (!awready);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		do @(negedge clk); while (!bvalid);
		check_val("bresp", flt ? RESP_SLVERR : RESP_OKAY, bresp);
		// Back-pressure, response must stay put
		stall = $urandom % 4;
		for (int k = 0; k < stall; k++) begin
			offer_blocked(k);
			check_val("bvalid", 1, bvalid);
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		bready = 1'b1;
		@(posedge clk);
		#1 bready = 1'b0;
		@(negedge clk);
		// Single response only
		check_val("bvalid", 0, bvalid);
		if (!flt) update_model(addr, wd, st);
	endtask

	task automatic host_read(input logic [31:0] addr, input logic [31:0] exp, input int flt);
		int stall;
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		#1 arvalid = 1'b0;
		do @(negedge clk); while (!rvalid);
		check_val("rresp", flt ? RESP_SLVERR : RESP_OKAY, rresp);
		check_val("rdata", exp, rdata);
		if (!flt && known[addr[11:2]]) check_val("rdata vs model", model[addr[11:2]], rdata);
		stall = $urandom % 4;
		for (int k = 0; k < stall; k++) begin
			offer_blocked(k);
			check_val("rvalid", 1, rvalid);
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		rready = 1'b1;
		@(posedge clk);
		#1 rready = 1'b0;
		@(negedge clk);
		check_val("rvalid", 0, rvalid);
	endtask

	//////////////////////////////
	// Core side
	//////////////////////////////

	task automatic core_access(input logic we, input logic [31:0] addr, input logic [31:0] wd,
		input logic [3:0] be, input logic [31:0] exp, input int flt);
		@(posedge clk);
		#1;
		data_req = 1'b1;
		data_we = we;
		data_addr = addr;
		data_wdata = wd;
		data_be = be;
		@(negedge clk);
		// Grant in the request cycle
		check_val("data_gnt", 1, data_gnt);
		@(posedge clk);
		#1 data_req = 1'b0;
		@(negedge clk);
		check_val("data_rvalid", 1, data_rvalid);
		check_val("data_fault", flt, data_fault);
		check_val("data_rdata", we ? 32'h0 : exp, data_rdata);
		if (!we && !flt && known[addr[11:2]]) begin
			check_val("data_rdata vs model", model[addr[11:2]], data_rdata);
		end
		if (we && !flt) update_model(addr, wd, be);
	endtask

	task automatic fetch(input logic [31:0] addr, input logic [31:0] exp, input int flt);
		@(posedge clk);
		#1;
		instr_rd = 1'b1;
		instr_addr = addr;
		@(negedge clk);
		check_val("instr_valid", 0, instr_valid);
		@(posedge clk);
		#1 instr_rd = 1'b0;
		@(negedge clk);
		check_val("instr_valid", 1, instr_valid);
		check_val("instr_fault", flt, instr_fault);
		check_val("instr_rdata", exp, instr_rdata);
	endtask

	task automatic run_step(input int i);
		if (step_noise[i]) begin
			@(negedge clk);
			noise_on = 1'b1;
		end
		case (step_op[i])
			"HW": host_write(step_addr[i], step_wdata[i], step_strb[i], step_flt[i]);
			"HR": host_read(step_addr[i], step_exp[i], step_flt[i]);
			"CW": core_access(1'b1, step_addr[i], step_wdata[i], step_strb[i], 0, step_flt[i]);
			"CR": core_access(1'b0, step_addr[i], 0, step_strb[i], step_exp[i], step_flt[i]);
			"IF": fetch(step_addr[i], step_exp[i], step_flt[i]);
			default: begin
				errors++;
				$display("Unknown operation in test step %0d", i);
			end
		endcase
		if (step_noise[i]) begin
			@(negedge clk);
			noise_on = 1'b0;
			repeat (2) @(posedge clk);
		end
	endtask

	//////////////////////////////
	// Random core traffic
	//////////////////////////////

	// Reads of preloaded words only, so host steps never race them
	initial begin
		logic        c_dreq, c_irq, p_dreq, p_irq, was_on;
		logic [31:0] c_daddr, c_iaddr, p_daddr, p_iaddr;
		c_dreq = 1'b0;
		c_irq = 1'b0;
		was_on = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			p_dreq = c_dreq;
			p_daddr = c_daddr;
			p_irq = c_irq;
			p_iaddr = c_iaddr;
			c_dreq = 1'b0;
			c_irq = 1'b0;
			if (noise_on) begin
				c_dreq = ($urandom % 3) == 0;
				c_daddr = 32'h400 + 4 * ($urandom % 4);
				c_irq = $urandom % 2;
				c_iaddr = 4 * ($urandom % 4);
				data_req = c_dreq;
				data_we = 1'b0;
				data_addr = c_daddr;
				data_be = 4'hf;
				instr_rd = c_irq;
				instr_addr = c_iaddr;
			end else if (was_on) begin
				data_req = 1'b0;
				instr_rd = 1'b0;
			end
			was_on = noise_on;
			@(negedge clk);
			if (c_dreq) check_val("data_gnt", 1, data_gnt);
			if (p_dreq) begin
				check_val("data_rvalid", 1, data_rvalid);
				check_val("data_fault", 0, data_fault);
				if (known[p_daddr[11:2]]) check_val("data_rdata", model[p_daddr[11:2]], data_rdata);
			end
			if (p_irq) begin
				check_val("instr_valid", 1, instr_valid);
				check_val("instr_fault", 0, instr_fault);
				if (known[p_iaddr[11:2]]) check_val("instr_rdata", model[p_iaddr[11:2]], instr_rdata);
			end
		end
	end

	// Run limit from the step count
	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int          fd;
		int          rc;
		int          seed;
		string       line;
		seed = $urandom(32'h58d9);
		{instr_rd, data_req, data_we, awvalid, wvalid, bready, arvalid, rready} = '0;
		{instr_addr, data_addr, awaddr, araddr, data_wdata, wdata} = '0;
		data_be = '0;
		wstrb = '0;
		arst_n = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) known[i] = 1'b0;
		fd = $fopen("bench/mem_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/mem_tests.txt");
			$display("Some tests failed");
			$finish;
		end else begin
			while (!$feof(fd) && n_steps < 64) begin
				line = "";
				rc = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") begin
					rc = $sscanf(line, "%s %h %h %h %h %d %d", step_op[n_steps],
						step_addr[n_steps], step_wdata[n_steps], step_strb[n_steps],
						step_exp[n_steps], step_flt[n_steps], step_noise[n_steps]);
					if (rc == 7) n_steps++;
				end
			end
			$fclose(fd);
			limit = n_steps * 30 + 200;
			repeat (3) @(posedge clk);
			#1 arst_n = 1'b1;
			// Idle outputs after reset
			@(negedge clk);
			check_val("awready", 0, awready);
			check_val("wready", 0, wready);
			check_val("arready", 0, arready);
			check_val("bvalid", 0, bvalid);
			check_val("rvalid", 0, rvalid);
			check_val("instr_valid", 0, instr_valid);
			check_val("data_gnt", 0, data_gnt);
			check_val("data_rvalid", 0, data_rvalid);
			check_val("instr_fault", 0, instr_fault);
			check_val("data_fault", 0, data_fault);
			for (int i = 0; i < n_steps; i++) run_step(i);
			repeat (3) @(posedge clk);
			$display("Steps run: %0d, errors: %0d", n_steps, errors);
			if (errors == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
			$finish;
		end
	end

endmodule

/* bench/mem_tests.txt */
# op addr wdata strb expect fault noise (hex except fault and noise)
# HW/HR host write/read, CW/CR core data write/read, IF fetch
HW 00000000 00000013 f 00000000 0 0
HW 00000004 00100093 f 00000000 0 0
HW 00000008 00208113 f 00000000 0 0
HW 0000000c 0000006f f 00000000 0 0
HW 00000400 11111111 f 00000000 0 0
HW 00000404 22222222 f 00000000 0 0
HW 00000408 33333333 f 00000000 0 0
HW 0000040c 44444444 f 00000000 0 0
HR 00000004 00000000 0 00100093 0 0
HW 00000800 aabbccdd f 00000000 0 0
HW 00000800 11223344 3 00000000 0 0
HR 00000800 00000000 0 aabb3344 0 0
HW 00000800 99000000 8 00000000 0 0
HR 00000800 00000000 0 99bb3344 0 0
HW 00001000 12345678 f 00000000 1 0
HR 00001000 00000000 0 00000000 1 0
HR 00002000 00000000 0 00000000 1 0
IF 00000000 00000000 0 00000013 0 0
IF 0000000c 00000000 0 0000006f 0 0
IF 00000400 00000000 0 00000000 1 0
IF 00001000 00000000 0 00000000 1 0
CW 00000900 deadbeef f 00000000 0 0
CR 00000900 00000000 f deadbeef 0 0
CW 00000900 000000ff 1 00000000 0 0
CW 00000900 55000000 8 00000000 0 0
CR 00000900 00000000 f 55adbeff 0 0
CW 00000000 ffffffff f 00000000 1 0
HR 00000000 00000000 0 00000013 0 0
CW 00001000 ffffffff f 00000000 1 0
CR 00000200 00000000 f 00000000 1 0
CR 00001004 00000000 f 00000000 1 0
HR 00000900 00000000 0 55adbeff 0 0
HW 00000a00 cafef00d f 00000000 0 1
HR 00000a00 00000000 0 cafef00d 0 1
HW 00000a00 0000beef 3 00000000 0 1
HR 00000a00 00000000 0 cafebeef 0 1
HR 00000800 00000000 0 99bb3344 0 1
HW 00000ffc 87654321 f 00000000 0 1
HR 00000ffc 00000000 0 87654321 0 1
HR 00000008 00000000 0 00208113 0 1
HW 00001004 0badf00d f 00000000 1 1
HR 00003000 00000000 0 00000000 1 1
HR 00000900 00000000 0 55adbeff 0 1
HR 0000040c 00000000 0 44444444 0 1

/* compile.f */
logic/mem_pkg.sv
logic/addr_decode.sv
logic/dual_port_ram.sv
logic/axil_slave.sv
logic/mem_ctrl.sv
logic/mem_subsys_top.sv
bench/tb_mem_subsys.sv
